// File: src/cam_cfg_pkg.sv
package cam_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // clocking and bus constants
    ////////////////////////////////////////////////////////////////////////////
    localparam int SYS_CLK_HZ = 50_000_000;
    localparam int SCL_HZ     = 200_000;
    localparam int DIV_CNT    = SYS_CLK_HZ / SCL_HZ;   // 250 sys clocks per scl

    localparam logic [6:0] DEV_ADDR  = 7'h3C;          // camera sccb address
    localparam int         TABLE_LEN = 8;

    // value doubles as the r/w bit of the address byte
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } sccb_op_e;

    typedef struct packed {
        logic        start;
        sccb_op_e    op;
        logic [15:0] reg_addr;
        logic [7:0]  wdata;
    } sccb_cmd_t;

    typedef struct packed {
        logic       done;
        logic       nack;
        logic [7:0] rdata;
    } sccb_rsp_t;

    typedef struct packed {
        logic [15:0] reg_addr;
        logic [7:0]  value;
    } cfg_entry_t;

    typedef struct packed {
        logic        rd;
        logic [15:0] reg_addr;
    } host_req_t;

    typedef enum logic [2:0] {
        M_IDLE, M_START, M_TX_BYTE, M_TX_ACK, M_RSTART, M_RX_BYTE, M_RX_NACK, M_STOP
    } master_state_e;

    typedef enum logic [2:0] {
        SEQ_IDLE, SEQ_ISSUE, SEQ_WAIT, SEQ_HOST_WAIT, SEQ_DONE, SEQ_ERR
    } seq_state_e;

endpackage

// File: src/scl_timer.sv
`timescale 1ns/1ps

module scl_timer (
    input  logic sys_clk,
    input  logic sys_rst_n,
    output logic scl_level,
    output logic mid_high,
    output logic mid_low
);

    logic [7:0] div_cnt;    // wraps once per scl period

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            div_cnt <= 8'd0;
        end else if (div_cnt == 8'(cam_cfg_pkg::DIV_CNT - 1)) begin
            div_cnt <= 8'd0;
        end else begin
            div_cnt <= div_cnt + 8'd1;
        end
    end

    // high for the first half, low for the second
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            scl_level <= 1'b1;
            mid_high  <= 1'b0;
            mid_low   <= 1'b0;
        end else begin
            if (div_cnt == 8'(cam_cfg_pkg::DIV_CNT / 2 - 1))
                scl_level <= 1'b0;
            else if (div_cnt == 8'(cam_cfg_pkg::DIV_CNT - 1))
                scl_level <= 1'b1;
            mid_high <= (div_cnt == 8'(cam_cfg_pkg::DIV_CNT / 4));     // quarter point
            mid_low  <= (div_cnt == 8'(cam_cfg_pkg::DIV_CNT / 2 + cam_cfg_pkg::DIV_CNT / 4));
        end
    end

    // each strobe sits inside its own scl phase, so the two never meet
    a_strobes_apart : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (!mid_high || scl_level) && (!mid_low || !scl_level));

endmodule

// File: src/sccb_master.sv
`timescale 1ns/1ps

module sccb_master (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  cam_cfg_pkg::sccb_cmd_t cmd,
    input  logic                   scl_level,
    input  logic                   mid_high,
    input  logic                   mid_low,
    output cam_cfg_pkg::sccb_rsp_t rsp,
    output logic                   busy,
    output logic                   scl,
    inout  wire                    sda
);

    cam_cfg_pkg::master_state_e state;
    cam_cfg_pkg::sccb_op_e      op_q;

    logic [3:0]  bit_cnt;       // bits sent or sampled in current byte
    logic [2:0]  byte_num;      // 0 dev w, 1 reg hi, 2 reg lo, 3 data, 4 dev r
    logic        sda_oe;        // pull sda low when set
    logic        done_q;
    logic        nack_q;
    logic [7:0]  shreg;
    logic [15:0] reg_addr_q;
    logic [7:0]  wdata_q;
    logic        accept;
    logic        ack_ok;

    assign sda    = sda_oe ? 1'b0 : 1'bz;   // open drain
    assign ack_ok = (sda == 1'b0);
    assign accept = (state == cam_cfg_pkg::M_IDLE) && cmd.start;
    assign busy   = (state != cam_cfg_pkg::M_IDLE);
    assign scl    = busy ? scl_level : 1'b1;
    assign rsp    = '{done: done_q, nack: nack_q, rdata: shreg};

    ////////////////////////////////////////////////////////////////////////////
    // transfer control
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= cam_cfg_pkg::M_IDLE;
            bit_cnt  <= 4'd0;
            byte_num <= 3'd0;
            sda_oe   <= 1'b0;
            done_q   <= 1'b0;
            nack_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                cam_cfg_pkg::M_IDLE: begin
                    if (cmd.start) begin
                        nack_q <= 1'b0;
                        state  <= cam_cfg_pkg::M_START;
                    end
                end
                cam_cfg_pkg::M_START: begin
                    if (mid_high) begin
                        sda_oe   <= 1'b1;       // start condition
                        bit_cnt  <= 4'd0;
                        byte_num <= 3'd0;
                        state    <= cam_cfg_pkg::M_TX_BYTE;
                    end
                end
                cam_cfg_pkg::M_TX_BYTE: begin
                    if (mid_low) begin
                        if (bit_cnt == 4'd8) begin
                            sda_oe <= 1'b0;     // hand sda to slave for ack
                            state  <= cam_cfg_pkg::M_TX_ACK;
                        end else begin
                            sda_oe  <= ~shreg[7];
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                cam_cfg_pkg::M_TX_ACK: begin
                    if (mid_high) begin
                        bit_cnt <= 4'd0;
                        if (!ack_ok) begin
                            nack_q <= 1'b1;
                            state  <= cam_cfg_pkg::M_STOP;
                        end else begin
                            case (byte_num)
                                3'd0, 3'd1: begin
                                    byte_num <= byte_num + 3'd1;
                                    state    <= cam_cfg_pkg::M_TX_BYTE;
                                end
                                3'd2: begin
                                    if (op_q == cam_cfg_pkg::OP_READ) begin
                                        state <= cam_cfg_pkg::M_RSTART;
                                    end else begin
                                        byte_num <= 3'd3;
                                        state    <= cam_cfg_pkg::M_TX_BYTE;
                                    end
                                end
                                3'd4:    state <= cam_cfg_pkg::M_RX_BYTE;
                                default: state <= cam_cfg_pkg::M_STOP;
                            endcase
                        end
                    end
                end
                cam_cfg_pkg::M_RSTART: begin
                    if (mid_high) begin
                        sda_oe   <= 1'b1;       // repeated start
                        byte_num <= 3'd4;
                        state    <= cam_cfg_pkg::M_TX_BYTE;
                    end
                end
                cam_cfg_pkg::M_RX_BYTE: begin
                    if (mid_high) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd7)
                            state <= cam_cfg_pkg::M_RX_NACK;
                    end
                end
                cam_cfg_pkg::M_RX_NACK: begin
                    // sda stays released through the ninth clock
                    if (mid_high)
                        state <= cam_cfg_pkg::M_STOP;
                end
                cam_cfg_pkg::M_STOP: begin
                    if (mid_low) begin
                        sda_oe <= 1'b1;
                    end else if (mid_high && sda_oe) begin
                        sda_oe <= 1'b0;         // sda rises with scl high
                        done_q <= 1'b1;
                        state  <= cam_cfg_pkg::M_IDLE;
                    end
                end
                default: begin
                    sda_oe <= 1'b0;
                    state  <= cam_cfg_pkg::M_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // command latch and shift register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            op_q       <= cmd.op;
            reg_addr_q <= cmd.reg_addr;
            wdata_q    <= cmd.wdata;
            shreg      <= {cam_cfg_pkg::DEV_ADDR, cam_cfg_pkg::OP_WRITE};
        end else if (state == cam_cfg_pkg::M_TX_BYTE && mid_low && bit_cnt != 4'd8) begin
            shreg <= {shreg[6:0], 1'b0};
        end else if (state == cam_cfg_pkg::M_TX_ACK && mid_high) begin
            case (byte_num)
                3'd0:    shreg <= reg_addr_q[15:8];
                3'd1:    shreg <= reg_addr_q[7:0];
                3'd2:    shreg <= wdata_q;          // unused on reads
                default: shreg <= shreg;
            endcase
        end else if (state == cam_cfg_pkg::M_RSTART && mid_high) begin
            shreg <= {cam_cfg_pkg::DEV_ADDR, cam_cfg_pkg::OP_READ};
        end else if (state == cam_cfg_pkg::M_RX_BYTE && mid_high) begin
            shreg <= {shreg[6:0], sda};             // msb first
        end
    end

    a_done_pulse : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        rsp.done |=> !rsp.done);

    a_idle_release : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (state == cam_cfg_pkg::M_IDLE) |-> !sda_oe);

endmodule

// File: src/cam_reg_table.sv
`timescale 1ns/1ps

module cam_reg_table (
    input  logic [2:0]              entry_idx,
    output cam_cfg_pkg::cfg_entry_t entry
);

    // power-up settings, every address appears once
    always_comb begin
        case (entry_idx)
            3'd0: begin
                entry.reg_addr = 16'h3103;  // sys clock from pad
                entry.value    = 8'h11;
            end
            3'd1: begin
                entry.reg_addr = 16'h3008;  // software power down
                entry.value    = 8'h42;
            end
            3'd2: begin
                entry.reg_addr = 16'h3037;  // pll root divider
                entry.value    = 8'h13;
            end
            3'd3: begin
                entry.reg_addr = 16'h3035;  // pll control
                entry.value    = 8'h21;
            end
            3'd4: begin
                entry.reg_addr = 16'h3036;  // pll multiplier
                entry.value    = 8'h69;
            end
            3'd5: begin
                entry.reg_addr = 16'h3108;  // pclk divider
                entry.value    = 8'h01;
            end
            3'd6: begin
                entry.reg_addr = 16'h4300;  // rgb565 output
                entry.value    = 8'h61;
            end
            default: begin
                entry.reg_addr = 16'h501F;  // isp format mux
                entry.value    = 8'h01;
            end
        endcase
    end

endmodule

// File: src/cam_cfg_seq.sv
`timescale 1ns/1ps

module cam_cfg_seq (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  logic                    cfg_start,
    input  cam_cfg_pkg::host_req_t  host_req,
    input  cam_cfg_pkg::cfg_entry_t entry,
    input  cam_cfg_pkg::sccb_rsp_t  rsp,
    input  logic                    busy,
    output logic [2:0]              entry_idx,
    output cam_cfg_pkg::sccb_cmd_t  cmd,
    output logic                    cfg_done,
    output logic                    cfg_err,
    output logic                    rd_valid,
    output logic [7:0]              rd_data,
    output logic                    rd_nack
);

    cam_cfg_pkg::seq_state_e state;

    logic settled;      // table finished, good or bad
    logic restart;
    logic host_accept;

    assign settled = (state == cam_cfg_pkg::SEQ_DONE) || (state == cam_cfg_pkg::SEQ_ERR);
    assign restart = cfg_start && (settled || state == cam_cfg_pkg::SEQ_IDLE);
    assign host_accept = host_req.rd && settled && !cfg_start;     // start wins a tie

    always_comb begin
        cmd.start = ((state == cam_cfg_pkg::SEQ_ISSUE) && !busy) || host_accept;
        cmd.wdata = entry.value;
        if (state == cam_cfg_pkg::SEQ_ISSUE) begin
            cmd.op       = cam_cfg_pkg::OP_WRITE;
            cmd.reg_addr = entry.reg_addr;
        end else begin
            cmd.op       = cam_cfg_pkg::OP_READ;
            cmd.reg_addr = host_req.reg_addr;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state     <= cam_cfg_pkg::SEQ_IDLE;
            entry_idx <= 3'd0;
            cfg_done  <= 1'b0;
            cfg_err   <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            rd_valid <= 1'b0;
            if (restart) begin
                entry_idx <= 3'd0;
                cfg_done  <= 1'b0;
                cfg_err   <= 1'b0;
                state     <= cam_cfg_pkg::SEQ_ISSUE;
            end else begin
                case (state)
                    cam_cfg_pkg::SEQ_ISSUE: if (!busy) state <= cam_cfg_pkg::SEQ_WAIT;
                    cam_cfg_pkg::SEQ_WAIT: begin
                        if (rsp.done) begin
                            if (rsp.nack) begin
                                cfg_err <= 1'b1;    // first nack ends the table
                                state   <= cam_cfg_pkg::SEQ_ERR;
                            end else if (entry_idx == 3'(cam_cfg_pkg::TABLE_LEN - 1)) begin
                                cfg_done <= 1'b1;
                                state    <= cam_cfg_pkg::SEQ_DONE;
                            end else begin
                                entry_idx <= entry_idx + 3'd1;
                                state     <= cam_cfg_pkg::SEQ_ISSUE;
                            end
                        end
                    end
                    cam_cfg_pkg::SEQ_HOST_WAIT: begin
                        if (rsp.done) begin
                            rd_valid <= 1'b1;
                            state <= cfg_err ? cam_cfg_pkg::SEQ_ERR : cam_cfg_pkg::SEQ_DONE;
                        end
                    end
                    cam_cfg_pkg::SEQ_DONE, cam_cfg_pkg::SEQ_ERR: begin
                        if (host_accept)
                            state <= cam_cfg_pkg::SEQ_HOST_WAIT;
                    end
                    default: state <= cam_cfg_pkg::SEQ_IDLE;
                endcase
            end
        end
    end

    // read result goes out with rd_valid
    always_ff @(posedge sys_clk) begin
        if (state == cam_cfg_pkg::SEQ_HOST_WAIT && rsp.done) begin
            rd_data <= rsp.rdata;
            rd_nack <= rsp.nack;
        end
    end

    a_no_start_busy : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !(cmd.start && busy));

endmodule

// File: src/cam_cfg_top.sv
`timescale 1ns/1ps

module cam_cfg_top (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  logic                   cfg_start,
    input  cam_cfg_pkg::host_req_t host_req,
    output logic                   cfg_done,
    output logic                   cfg_err,
    output logic                   rd_valid,
    output logic [7:0]             rd_data,
    output logic                   rd_nack,
    output logic                   scl,
    inout  wire                    sda
);

    logic                    scl_level;
    logic                    mid_high;
    logic                    mid_low;
    logic                    busy;
    logic [2:0]              entry_idx;
    cam_cfg_pkg::sccb_cmd_t  cmd;
    cam_cfg_pkg::sccb_rsp_t  rsp;
    cam_cfg_pkg::cfg_entry_t entry;

    scl_timer scl_timer_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .scl_level (scl_level),
        .mid_high  (mid_high),
        .mid_low   (mid_low)
    );

    sccb_master sccb_master_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .cmd       (cmd),
        .scl_level (scl_level),
        .mid_high  (mid_high),
        .mid_low   (mid_low),
        .rsp       (rsp),
        .busy      (busy),
        .scl       (scl),
        .sda       (sda)
    );

    cam_reg_table cam_reg_table_i (
        .entry_idx (entry_idx),
        .entry     (entry)
    );

    cam_cfg_seq cam_cfg_seq_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .cfg_start (cfg_start),
        .host_req  (host_req),
        .entry     (entry),
        .rsp       (rsp),
        .busy      (busy),
        .entry_idx (entry_idx),
        .cmd       (cmd),
        .cfg_done  (cfg_done),
        .cfg_err   (cfg_err),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_nack   (rd_nack)
    );

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic sys_clk,
    output logic sys_rst_n
);

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;    // 20 ns period
    end

    initial begin
        sys_rst_n = 1'b0;
        repeat (2) @(posedge sys_clk);
        #1 sys_rst_n = 1'b1;
    end

endmodule

// File: bench/sccb_slave_model.sv
`timescale 1ns/1ps

module sccb_slave_model (
    input  logic scl,
    inout  wire  sda,
    input  logic mute
);

    typedef enum logic [2:0] {
        S_IDLE, S_RX, S_ACK, S_TX, S_MACK
    } slave_mode_e;

    slave_mode_e mode = S_IDLE;

    logic [7:0]  mem [0:65535];
    logic [7:0]  shift;
    logic [7:0]  tx_byte;
    logic [15:0] reg_addr;
    logic [3:0]  bit_cnt;
    logic [2:0]  byte_idx;      // 0 dev, 1 reg hi, 2 reg lo, 3 data
    logic        read_dir;
    logic        drive_low = 1'b0;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        for (int a = 0; a < 65536; a++)
            mem[a] = 8'(a) ^ 8'h5A;
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus conditions, sda moving while scl is high
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge sda) begin
        if (scl === 1'b1) begin    // start or repeated start
            mode      = S_RX;
            bit_cnt   = 4'd0;
            byte_idx  = 3'd0;
            drive_low = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin    // stop
            mode      = S_IDLE;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (mode == S_RX && bit_cnt < 4'd8) begin
            shift   = {shift[6:0], sda};
            bit_cnt = bit_cnt + 4'd1;
        end
    end

    // sda only changes while scl is low
    always @(negedge scl) begin
        case (mode)
            S_RX: begin
                if (bit_cnt == 4'd8) begin
                    bit_cnt = 4'd0;
                    case (byte_idx)
                        3'd0: begin
                            if (shift[7:1] == cam_cfg_pkg::DEV_ADDR && !mute)
                                read_dir = shift[0];
                            else
                                mode = S_IDLE;     // nack, wait for stop
                        end
                        3'd1: reg_addr[15:8] = shift;
                        3'd2: reg_addr[7:0]  = shift;
                        3'd3: mem[reg_addr]  = shift;
                        default: ;
                    endcase
                    if (mode == S_RX) begin
                        drive_low = 1'b1;
                        mode      = S_ACK;
                        byte_idx  = byte_idx + 3'd1;
                    end
                end
            end
            S_ACK: begin
                drive_low = 1'b0;
                if (read_dir) begin
                    tx_byte   = mem[reg_addr];
                    drive_low = ~tx_byte[7];
                    bit_cnt   = 4'd1;
                    mode      = S_TX;
                end else begin
                    mode = S_RX;
                end
            end
            S_TX: begin
                if (bit_cnt == 4'd8) begin
                    drive_low = 1'b0;   // master acks or nacks
                    mode      = S_MACK;
                end else begin
                    drive_low = ~tx_byte[7 - bit_cnt];
                    bit_cnt   = bit_cnt + 4'd1;
                end
            end
            S_MACK: mode = S_IDLE;
            default: ;
        endcase
    end

endmodule

// File: bench/tb_cam_cfg.sv
`timescale 1ns/1ps

module tb_cam_cfg;

    localparam int RESET_LIMIT = 10;
    localparam int CFG_LIMIT   = 200_000;   // eight writes of ~38 scl periods each
    localparam int READ_LIMIT  = 40_000;

    typedef struct packed {
        logic        mute;
        logic        is_read;      // 0 means cfg_start
        logic [15:0] addr;
        logic [7:0]  exp_data;
        logic        exp_flag;     // cfg_err for starts, rd_nack for reads
    } row_t;

    logic                   sys_clk;
    logic                   sys_rst_n;
    logic                   cfg_start;
    cam_cfg_pkg::host_req_t host_req;
    logic                   cfg_done;
    logic                   cfg_err;
    logic                   rd_valid;
    logic [7:0]             rd_data;
    logic                   rd_nack;
    logic                   scl;
    logic                   mute;
    wire                    sda;

    logic [15:0] table_addr [0:7];
    logic [7:0]  table_val  [0:7];
    row_t        rows [$];
    integer      seed;
    logic [15:0] rand_addr;

    pullup (sda);

    clk_gen clk_gen_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n)
    );

    cam_cfg_top dut_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .cfg_start (cfg_start),
        .host_req  (host_req),
        .cfg_done  (cfg_done),
        .cfg_err   (cfg_err),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_nack   (rd_nack),
        .scl       (scl),
        .sda       (sda)
    );

    sccb_slave_model slave_i (
        .scl  (scl),
        .sda  (sda),
        .mute (mute)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        string line;
        if (actual !== expected) begin
            line = $sformatf("[FAIL] %s got %h expected %h", name, actual, expected);
            abort_run(line);
        end
    endtask

    // inputs change and outputs are read 1 ns after the edge
    task automatic step_cycle();
        @(posedge sys_clk);
        #1;
    endtask

    task automatic add_row(input logic mute_in, input logic is_read, input logic [15:0] addr,
                           input logic [7:0] exp_data, input logic exp_flag);
        rows.push_back('{mute: mute_in, is_read: is_read, addr: addr,
                         exp_data: exp_data, exp_flag: exp_flag});
    endtask

    function automatic logic in_table(input logic [15:0] addr);
        for (int k = 0; k < 8; k++)
            if (table_addr[k] == addr)
                return 1'b1;
        return 1'b0;
    endfunction

    task automatic wait_cfg_settled();
        int n;
        n = 0;
        while (!(cfg_done || cfg_err)) begin
            if (n == CFG_LIMIT)
                abort_run("timeout: configuration never reported done or error");
            step_cycle();
            n++;
        end
    endtask

    task automatic wait_read_valid();
        int n;
        n = 0;
        while (!rd_valid) begin
            if (n == READ_LIMIT)
                abort_run("timeout: host read never returned rd_valid");
            step_cycle();
            n++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int n;
        cfg_start = 1'b0;
        host_req  = '0;
        mute      = 1'b0;
        seed      = 32'h08f87945;
        table_addr = '{16'h3103, 16'h3008, 16'h3037, 16'h3035,
                       16'h3036, 16'h3108, 16'h4300, 16'h501F};
        table_val  = '{8'h11, 8'h42, 8'h13, 8'h21, 8'h69, 8'h01, 8'h61, 8'h01};

        add_row(1'b0, 1'b0, 16'h0000, 8'h00, 1'b0);     // full table
        for (int k = 0; k < 8; k++)
            add_row(1'b0, 1'b1, table_addr[k], table_val[k], 1'b0);
        for (int k = 0; k < 4; k++) begin
            rand_addr = 16'($random(seed));
            while (in_table(rand_addr))
                rand_addr = 16'($random(seed));
            add_row(1'b0, 1'b1, rand_addr, rand_addr[7:0] ^ 8'h5A, 1'b0);
        end
        add_row(1'b1, 1'b0, 16'h0000, 8'h00, 1'b1);     // muted slave
        add_row(1'b1, 1'b1, table_addr[2], 8'h00, 1'b1);
        add_row(1'b0, 1'b0, 16'h0000, 8'h00, 1'b0);     // recovery
        add_row(1'b0, 1'b1, table_addr[7], table_val[7], 1'b0);

        n = 0;
        while (sys_rst_n !== 1'b1) begin
            if (n == RESET_LIMIT)
                abort_run("timeout: reset was never released");
            step_cycle();
            n++;
        end
        step_cycle();

        // idle bus right after reset
        check_value("scl", scl, 16'h1);
        check_value("sda", sda, 16'h1);
        check_value("cfg_done", cfg_done, 16'h0);
        check_value("cfg_err", cfg_err, 16'h0);
        check_value("rd_valid", rd_valid, 16'h0);

        foreach (rows[i]) begin
            mute = rows[i].mute;
            if (rows[i].is_read) begin
                host_req.rd       = 1'b1;
                host_req.reg_addr = rows[i].addr;
                step_cycle();
                host_req.rd = 1'b0;
                wait_read_valid();
                check_value("rd_nack", rd_nack, 16'(rows[i].exp_flag));
                if (!rows[i].exp_flag)
                    check_value("rd_data", rd_data, 16'(rows[i].exp_data));
            end else begin
                cfg_start = 1'b1;
                step_cycle();
                cfg_start = 1'b0;
                wait_cfg_settled();
                check_value("cfg_err", cfg_err, 16'(rows[i].exp_flag));
                check_value("cfg_done", cfg_done, 16'(!rows[i].exp_flag));
            end
            step_cycle();
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// File: sim.f
src/cam_cfg_pkg.sv
src/scl_timer.sv
src/sccb_master.sv
src/cam_reg_table.sv
src/cam_cfg_seq.sv
src/cam_cfg_top.sv
bench/clk_gen.sv
bench/sccb_slave_model.sv
bench/tb_cam_cfg.sv
